// ==== Makefile ====
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
TOP        ?= csr_unit_tb
DUT_TOP    ?= csr_unit
FILELIST   ?= src.f
OBJ_DIR    ?= obj_dir
PASS_MSG   := test passed

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== design/csr_decode.sv ====
`timescale 1ns/1ps

module csr_decode (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   instr_valid,
    input  csr_pkg::csr_instr_u    instr,
    input  logic [31:0]            rs1_value,
    output csr_pkg::decode_stage_t decoded
);
    import csr_pkg::*;

    logic          is_csr;
    logic          use_imm;
    logic [4:0]    src_index;
    csr_op_e       op;
    decode_stage_t decode_next;

    // Opcode and funct3 sit at the same place in both views.
    always_comb begin
        is_csr = 1'b1;
        op     = op_write;
        case (instr.reg_view.funct3)
            funct3_csrrw, funct3_csrrwi: begin
                op = op_write;
            end
            funct3_csrrs, funct3_csrrsi: begin
                op = op_set;
            end
            funct3_csrrc, funct3_csrrci: begin
                op = op_clear;
            end
            default: begin
                is_csr = 1'b0; // ECALL, EBREAK and reserved.
            end
        endcase
        if (instr.reg_view.opcode != opcode_system) begin
            is_csr = 1'b0;
        end
    end

    assign use_imm = instr.reg_view.funct3[2];

    // Register index and zimm share the same five bits.
    assign src_index = instr.reg_view.rs1;

    always_comb begin
        decode_next.valid = instr_valid && is_csr;
        decode_next.op    = op;
        decode_next.addr  = instr.reg_view.csr;
        decode_next.rd    = instr.reg_view.rd;
        if (use_imm) begin
            decode_next.operand = {27'd0, instr.imm_view.zimm};
        end else begin
            decode_next.operand = rs1_value;
        end
        // Set or clear from x0 or zimm 0 only reads.
        decode_next.write = (op == op_write) || (src_index != 5'd0);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            decoded.valid <= 1'b0;
        end else begin
            decoded <= decode_next;
        end
    end

endmodule

// ==== design/csr_file.sv ====
`timescale 1ns/1ps

module csr_file (
    input  logic                   clk,
    input  logic                   reset,
    input  csr_pkg::decode_stage_t decoded,
    input  logic                   instr_retire,
    input  csr_pkg::csr_write_t    wr,
    output csr_pkg::read_stage_t   read_out,
    output csr_pkg::approx_ctrl_t  approx_ctrl
);
    import csr_pkg::*;

    logic [31:0] alucsr_q;
    logic [31:0] mulcsr_q;
    logic [31:0] divcsr_q;
    logic [63:0] mcycle_q;
    logic [63:0] minstret_q;

    logic [31:0] file_value;
    logic [31:0] read_value;
    logic        implemented;
    logic        read_only;
    logic        forward;
    read_stage_t read_next;

    // Read port.
    always_comb begin
        file_value  = 32'd0;
        implemented = 1'b1;
        read_only   = 1'b0;
        case (decoded.addr)
            addr_alucsr: begin
                file_value = alucsr_q;
            end
            addr_mulcsr: begin
                file_value = mulcsr_q;
            end
            addr_divcsr: begin
                file_value = divcsr_q;
            end
            addr_mcycle: begin
                file_value = mcycle_q[31:0];
                read_only  = 1'b1;
            end
            addr_mcycleh: begin
                file_value = mcycle_q[63:32];
                read_only  = 1'b1;
            end
            addr_minstret: begin
                file_value = minstret_q[31:0];
                read_only  = 1'b1;
            end
            addr_minstreth: begin
                file_value = minstret_q[63:32];
                read_only  = 1'b1;
            end
            default: begin
                implemented = 1'b0;
            end
        endcase
    end

    // Stage 3 commits at this same edge, so take its data directly.
    assign forward    = wr.enable && (wr.addr == decoded.addr);
    assign read_value = forward ? wr.data : file_value;

    always_comb begin
        read_next.dec         = decoded;
        read_next.old_value   = read_value;
        read_next.implemented = implemented;
        read_next.read_only   = read_only;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            read_out.dec.valid <= 1'b0;
        end else begin
            read_out <= read_next;
        end
    end

    // Write port for the approximation registers only.
    always_ff @(posedge clk) begin
        if (reset) begin
            alucsr_q <= 32'd0;
            mulcsr_q <= 32'd0;
            divcsr_q <= 32'd0;
        end else if (wr.enable) begin
            case (wr.addr)
                addr_alucsr: alucsr_q <= wr.data;
                addr_mulcsr: mulcsr_q <= wr.data;
                addr_divcsr: divcsr_q <= wr.data;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mcycle_q   <= 64'd0;
            minstret_q <= 64'd0;
        end else begin
            mcycle_q <= mcycle_q + 64'd1;
            if (instr_retire) begin
                minstret_q <= minstret_q + 64'd1;
            end
        end
    end

    always_comb begin
        approx_ctrl.alu = alucsr_q;
        approx_ctrl.mul = mulcsr_q;
        approx_ctrl.div = divcsr_q;
    end

endmodule

// ==== design/csr_pkg.sv ====
package csr_pkg;

    localparam logic [6:0] opcode_system = 7'b1110011;

    // Funct3 encodings of the Zicsr instructions.
    localparam logic [2:0] funct3_csrrw  = 3'b001;
    localparam logic [2:0] funct3_csrrs  = 3'b010;
    localparam logic [2:0] funct3_csrrc  = 3'b011;
    localparam logic [2:0] funct3_csrrwi = 3'b101;
    localparam logic [2:0] funct3_csrrsi = 3'b110;
    localparam logic [2:0] funct3_csrrci = 3'b111;

    // Approximation control registers in the custom machine range.
    localparam logic [11:0] addr_alucsr    = 12'h7C0;
    localparam logic [11:0] addr_mulcsr    = 12'h7C1;
    localparam logic [11:0] addr_divcsr    = 12'h7C2;

    localparam logic [11:0] addr_mcycle    = 12'hB00;
    localparam logic [11:0] addr_minstret  = 12'hB02;
    localparam logic [11:0] addr_mcycleh   = 12'hB80;
    localparam logic [11:0] addr_minstreth = 12'hB82;

    typedef struct packed {
        logic [11:0] csr;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } csr_reg_view_t;

    typedef struct packed {
        logic [11:0] csr;
        logic [4:0]  zimm; // Zero-extended immediate.
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } csr_imm_view_t;

    // Funct3 bit 2 selects which view holds for bits 19:15.
    typedef union packed {
        csr_reg_view_t reg_view;
        csr_imm_view_t imm_view;
    } csr_instr_u;

    typedef enum logic [1:0] {
        op_write = 2'd0,
        op_set   = 2'd1,
        op_clear = 2'd2
    } csr_op_e;

    typedef struct packed {
        logic        valid;
        csr_op_e     op;
        logic [11:0] addr;
        logic [4:0]  rd;
        logic [31:0] operand;
        logic        write; // Low for set/clear with a zero source.
    } decode_stage_t;

    typedef struct packed {
        decode_stage_t dec;
        logic [31:0]   old_value;
        logic          implemented;
        logic          read_only;
    } read_stage_t;

    typedef struct packed {
        logic        enable;
        logic [11:0] addr;
        logic [31:0] data;
    } csr_write_t;

    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic [31:0] data;
        logic        illegal;
    } csr_result_t;

    typedef struct packed {
        logic [31:0] alu;
        logic [31:0] mul;
        logic [31:0] div;
    } approx_ctrl_t;

endpackage

// ==== design/csr_unit.sv ====
`timescale 1ns/1ps

module csr_unit (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  instr_valid,
    input  csr_pkg::csr_instr_u   instr,
    input  logic [31:0]           rs1_value,
    input  logic                  instr_retire,
    output csr_pkg::csr_result_t  result,
    output csr_pkg::approx_ctrl_t approx_ctrl
);
    import csr_pkg::*;

    decode_stage_t decoded;
    read_stage_t   read_stage;
    csr_write_t    wr;

    // Stage 1.
    csr_decode u_decode (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rs1_value   (rs1_value),
        .decoded     (decoded)
    );

    // Stage 2 and the register storage.
    csr_file u_file (
        .clk          (clk),
        .reset        (reset),
        .decoded      (decoded),
        .instr_retire (instr_retire),
        .wr           (wr),
        .read_out     (read_stage),
        .approx_ctrl  (approx_ctrl)
    );

    // Stage 3 writes back to the file.
    csr_update u_update (
        .clk     (clk),
        .reset   (reset),
        .read_in (read_stage),
        .wr      (wr),
        .result  (result)
    );

endmodule

// ==== design/csr_update.sv ====
`timescale 1ns/1ps

module csr_update (
    input  logic                 clk,
    input  logic                 reset,
    input  csr_pkg::read_stage_t read_in,
    output csr_pkg::csr_write_t  wr,
    output csr_pkg::csr_result_t result
);
    import csr_pkg::*;

    logic [31:0] old_value;
    logic [31:0] operand;
    logic [31:0] new_value;
    logic        illegal;
    csr_result_t result_next;

    assign old_value = read_in.old_value;
    assign operand   = read_in.dec.operand;

    always_comb begin
        case (read_in.dec.op)
            op_write: new_value = operand;
            op_set:   new_value = old_value | operand;
            op_clear: new_value = old_value & ~operand;
            default:  new_value = old_value;
        endcase
    end

    // Counters may be read but never written.
    assign illegal = !read_in.implemented || (read_in.dec.write && read_in.read_only);

    // Committed by csr_file at the edge that registers the result.
    always_comb begin
        wr.enable = read_in.dec.valid && read_in.dec.write && !illegal;
        wr.addr   = read_in.dec.addr;
        wr.data   = new_value;
    end

    always_comb begin
        result_next.valid   = read_in.dec.valid;
        result_next.rd      = read_in.dec.rd;
        result_next.illegal = illegal;
        if (illegal) begin
            result_next.data = 32'd0;
        end else begin
            result_next.data = old_value; // rd gets the value before the update.
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result.valid <= 1'b0;
        end else begin
            result <= result_next;
        end
    end

endmodule

// ==== src.f ====
design/csr_pkg.sv
design/csr_decode.sv
design/csr_file.sv
design/csr_update.sv
design/csr_unit.sv
verification/csr_unit_tb.sv

// ==== verification/csr_unit_tb.sv ====
`timescale 1ns/1ps

module csr_unit_tb;
    import csr_pkg::*;

    typedef struct packed {
        csr_result_t  res;
        approx_ctrl_t ctrl;
    } expect_t;

    localparam int reset_cycles = 4;
    localparam int test_cycles  = 16 + 80 + 40 + 30 + 20; // Per-test budgets.
    localparam int max_cycles   = reset_cycles + test_cycles + 50;

    logic         clk;
    logic         reset;
    logic         instr_valid;
    csr_instr_u   instr;
    logic [31:0]  rs1_value;
    logic         instr_retire;
    csr_result_t  result;
    approx_ctrl_t approx_ctrl;

    // Reference model state in program order.
    approx_ctrl_t model_ctrl;
    logic [63:0]  mcycle_model;
    logic [63:0]  minstret_model;
    expect_t      pending[$];
    expect_t      exp_item; // Prediction for the next rising edge.
    int           fail_count;
    int           test_fails;
    int           test_count;
    int           cycle_count;

    csr_unit dut (
        .clk          (clk),
        .reset        (reset),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .rs1_value    (rs1_value),
        .instr_retire (instr_retire),
        .result       (result),
        .approx_ctrl  (approx_ctrl)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        if (reset) begin
            mcycle_model   <= 64'd0;
            minstret_model <= 64'd0;
        end else begin
            mcycle_model <= mcycle_model + 64'd1;
            if (instr_retire) begin
                minstret_model <= minstret_model + 64'd1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("The run timed out after %0d cycles without finishing.", cycle_count);
            $display("test failed");
            $finish;
        end
    end

    result_valid_check: assert property (@(posedge clk) disable iff (reset)
        result.valid == exp_item.res.valid)
    else begin
        fail_count++;
        $display("FAIL %0t: result.valid is %0b, expected %0b", $time,
                 $sampled(result.valid), $sampled(exp_item.res.valid));
    end

    result_data_check: assert property (@(posedge clk) disable iff (reset)
        exp_item.res.valid |-> (result.rd == exp_item.res.rd &&
                                result.data == exp_item.res.data &&
                                result.illegal == exp_item.res.illegal))
    else begin
        fail_count++;
        $display("FAIL %0t: result is %h, expected %h", $time,
                 $sampled(result), $sampled(exp_item.res));
    end

    approx_ctrl_check: assert property (@(posedge clk) disable iff (reset)
        approx_ctrl == exp_item.ctrl)
    else begin
        fail_count++;
        $display("FAIL %0t: approx_ctrl is %h, expected %h", $time,
                 $sampled(approx_ctrl), $sampled(exp_item.ctrl));
    end

    function automatic logic [31:0] encode_csr(input logic [2:0] funct3,
                                               input logic [11:0] addr,
                                               input logic [4:0] src,
                                               input logic [4:0] rd);
        return {addr, src, funct3, rd, opcode_system};
    endfunction

    function automatic logic [11:0] pick_addr(input int idx);
        case (idx)
            0: return addr_alucsr;
            1: return addr_mulcsr;
            default: return addr_divcsr;
        endcase
    endfunction

    function automatic logic [2:0] pick_funct3(input int idx);
        case (idx)
            0: return funct3_csrrw;
            1: return funct3_csrrs;
            2: return funct3_csrrc;
            3: return funct3_csrrwi;
            4: return funct3_csrrsi;
            default: return funct3_csrrci;
        endcase
    endfunction

    // Predicts one cycle of input; the result surfaces three edges later.
    task automatic model_step(input logic valid, input logic [31:0] word,
                              input logic [31:0] rs1, input logic retire);
        logic [2:0]  funct3;
        logic [4:0]  src;
        logic [11:0] addr;
        logic        is_csr;
        logic        writes;
        logic        writable;
        logic        impl;
        logic [31:0] operand;
        logic [31:0] old;
        logic [31:0] new_value;
        logic [63:0] cycle_at_read;
        logic [63:0] instret_at_read;
        expect_t     item;
        funct3          = word[14:12];
        src             = word[19:15];
        addr            = word[31:20];
        is_csr          = valid && (word[6:0] == opcode_system) && (funct3[1:0] != 2'b00);
        operand         = funct3[2] ? {27'd0, src} : rs1;
        writes          = (funct3[1:0] == 2'b01) || (src != 5'd0);
        cycle_at_read   = mcycle_model + 64'd1; // Stage 2 sits one edge later.
        instret_at_read = minstret_model + {63'd0, retire};
        impl            = 1'b1;
        writable        = 1'b0;
        old             = 32'd0;
        case (addr)
            addr_alucsr: begin
                old      = model_ctrl.alu;
                writable = 1'b1;
            end
            addr_mulcsr: begin
                old      = model_ctrl.mul;
                writable = 1'b1;
            end
            addr_divcsr: begin
                old      = model_ctrl.div;
                writable = 1'b1;
            end
            addr_mcycle:    old = cycle_at_read[31:0];
            addr_mcycleh:   old = cycle_at_read[63:32];
            addr_minstret:  old = instret_at_read[31:0];
            addr_minstreth: old = instret_at_read[63:32];
            default:        impl = 1'b0;
        endcase
        case (funct3[1:0])
            2'b01:   new_value = operand;
            2'b10:   new_value = old | operand;
            default: new_value = old & ~operand;
        endcase
        item.res.valid   = is_csr;
        item.res.rd      = word[11:7];
        item.res.illegal = !impl || (writes && !writable);
        item.res.data    = item.res.illegal ? 32'd0 : old;
        if (is_csr && writes && !item.res.illegal) begin
            case (addr)
                addr_alucsr: model_ctrl.alu = new_value;
                addr_mulcsr: model_ctrl.mul = new_value;
                default:     model_ctrl.div = new_value;
            endcase
        end
        item.ctrl = model_ctrl;
        pending.push_back(item);
        if (pending.size() > 3) begin
            exp_item = pending.pop_front();
        end
    endtask

    task automatic drive(input logic valid, input logic [31:0] word,
                         input logic [31:0] rs1, input logic retire);
        @(negedge clk);
        instr_valid  = valid;
        instr        = word;
        rs1_value    = rs1;
        instr_retire = retire;
        model_step(valid, word, rs1, retire);
    endtask

    task automatic issue(input logic [31:0] word, input logic [31:0] rs1);
        drive(1'b1, word, rs1, 1'b0);
    endtask

    task automatic idle();
        drive(1'b0, 32'd0, 32'd0, 1'b0);
    endtask

    task automatic begin_test();
        test_fails = fail_count;
    endtask

    task automatic end_test(input string name);
        repeat (4) idle(); // Drain the pipeline.
        test_count++;
        $display("%s: %0d failing checks", name, fail_count - test_fails);
    endtask

    initial begin
        void'($urandom(32'hd9abb00a));
        clk          = 1'b0;
        reset        = 1'b1;
        instr_valid  = 1'b0;
        instr        = 32'd0;
        rs1_value    = 32'd0;
        instr_retire = 1'b0;
        model_ctrl   = '0;
        exp_item     = '0;
        fail_count   = 0;
        test_count   = 0;
        cycle_count  = 0;
        repeat (reset_cycles) idle();
        reset = 1'b0;

        begin_test();
        repeat (3) idle();
        issue(encode_csr(funct3_csrrs, addr_alucsr, 5'd0, 5'd1), 32'hffff_ffff);
        issue(encode_csr(funct3_csrrs, addr_mulcsr, 5'd0, 5'd2), 32'hffff_ffff);
        issue(encode_csr(funct3_csrrc, addr_divcsr, 5'd0, 5'd3), 32'hffff_ffff);
        end_test("reset values");

        begin_test();
        for (int round = 0; round < 2; round++) begin
            for (int r = 0; r < 3; r++) begin
                for (int f = 0; f < 6; f++) begin
                    issue(encode_csr(pick_funct3(f), pick_addr(r),
                                     5'($urandom_range(31, 1)), 5'($urandom)), $urandom);
                    if (round == 0) begin
                        idle();
                    end
                end
            end
        end
        end_test("random csr operations");

        begin_test();
        issue(encode_csr(funct3_csrrw, addr_mulcsr, 5'd3, 5'd4), 32'ha5a5_0f0f);
        issue(encode_csr(funct3_csrrs, addr_mulcsr, 5'd5, 5'd4), 32'h0000_f0f0);
        issue(encode_csr(funct3_csrrs, addr_mulcsr, 5'd0, 5'd6), 32'hffff_ffff); // x0 source.
        issue(encode_csr(funct3_csrrc, addr_mulcsr, 5'd7, 5'd6), 32'h0000_00ff);
        issue(encode_csr(funct3_csrrci, addr_mulcsr, 5'd0, 5'd8), 32'd0);
        issue(encode_csr(funct3_csrrsi, addr_mulcsr, 5'd0, 5'd8), 32'd0);
        issue(encode_csr(funct3_csrrci, addr_mulcsr, 5'd15, 5'd9), 32'd0);
        issue(encode_csr(funct3_csrrwi, addr_alucsr, 5'd31, 5'd9), 32'd0);
        issue(encode_csr(funct3_csrrs, addr_alucsr, 5'd1, 5'd10), $urandom);
        issue(encode_csr(funct3_csrrc, addr_alucsr, 5'd0, 5'd10), 32'hffff_ffff);
        repeat (8) begin
            issue(encode_csr(pick_funct3(int'($urandom_range(5, 0))), addr_divcsr,
                             5'($urandom), 5'd11), $urandom);
        end
        end_test("back-to-back forwarding");

        begin_test();
        issue(encode_csr(funct3_csrrs, addr_mcycle, 5'd0, 5'd1), 32'd0);
        issue(encode_csr(funct3_csrrs, addr_mcycle, 5'd0, 5'd2), 32'd0);
        issue(encode_csr(funct3_csrrc, addr_mcycleh, 5'd0, 5'd3), 32'd0);
        repeat (5) drive(1'b0, 32'd0, 32'd0, 1'b1);
        idle();
        issue(encode_csr(funct3_csrrs, addr_minstret, 5'd0, 5'd4), 32'd0);
        issue(encode_csr(funct3_csrrsi, addr_minstreth, 5'd0, 5'd5), 32'd0);
        drive(1'b1, encode_csr(funct3_csrrs, addr_minstret, 5'd0, 5'd6), 32'd0, 1'b1);
        issue(encode_csr(funct3_csrrs, addr_minstret, 5'd0, 5'd7), 32'd0);
        end_test("counters");

        begin_test();
        issue(encode_csr(funct3_csrrw, 12'h123, 5'd1, 5'd2), $urandom); // Unimplemented.
        issue(encode_csr(funct3_csrrs, 12'h7c3, 5'd0, 5'd2), 32'd0);
        issue(encode_csr(funct3_csrrw, addr_mcycle, 5'd1, 5'd3), $urandom);
        issue(encode_csr(funct3_csrrs, addr_mcycle, 5'd0, 5'd4), 32'd0);
        issue(encode_csr(funct3_csrrsi, addr_minstreth, 5'd4, 5'd3), 32'd0);
        issue(32'h0000_0073, 32'd0); // ECALL.
        issue(32'h0020_81b3, $urandom); // ADD x3, x1, x2.
        issue(encode_csr(3'b100, addr_alucsr, 5'd1, 5'd1), 32'hffff_ffff);
        end_test("illegal instructions");

        $display("%0d tests run, %0d failing checks in total", test_count, fail_count);
        if (fail_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
